/* include/netfifo_config.svh */
// Build-time sizing for the abortable packet FIFO
// Data word width and buffer depth, shared by packages and RTL

`ifndef NETFIFO_CONFIG_SVH
`define NETFIFO_CONFIG_SVH

//////////////////////////////
// Stream word
//////////////////////////////

// Bits per stream beat, one byte by default
`define NETFIFO_DATA_W 8

//////////////////////////////
// Buffer sizing
//////////////////////////////

// Log2 of entry count, 16 entries by default
`define NETFIFO_LG_DEPTH 4

`endif

/* verilog/stream_pkg.sv */
// Stream datapath types for the packet FIFO
// Data word plus buffer pointer and index widths

`default_nettype none

`include "netfifo_config.svh"

package stream_pkg;

	// One beat of stream payload
	typedef logic [`NETFIFO_DATA_W-1:0] data_t;

	// Pointer with one extra wrap bit
	// Difference of two pointers spans 0 to depth
	typedef logic [`NETFIFO_LG_DEPTH:0] ptr_t;

	// Plain buffer slot index
	typedef logic [`NETFIFO_LG_DEPTH-1:0] index_t;

endpackage

`default_nettype wire

/* verilog/fifo_ctrl_pkg.sv */
// Control types for the packet FIFO
// Write-side packet state and write-pointer opcodes

`default_nettype none

`include "netfifo_config.svh"

package fifo_ctrl_pkg;

	// Write side, outside or inside a packet
	typedef enum logic {
		pkt_idle,
		pkt_body
	} pkt_state_t;

	// Write-pointer operation for one cycle
	typedef enum logic [2:0] {
		wr_hold,
		wr_push,
		wr_push_eop,
		wr_rewind_eop,
		wr_rewind_read
	} wr_op_t;

endpackage

`default_nettype wire

/* verilog/packet_fifo_ctrl.sv */
// Packet FIFO control
// Handshakes, packet tracking, abort handling and pointer opcode decode
// m_abort is the only registered output

`timescale 1ns/100ps
`default_nettype none

module packet_fifo_ctrl (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Write side
	input wire s_valid,
	input wire s_last,
	input wire s_abort,
	output logic s_ready,
	// Read side
	output logic m_valid,
	input wire m_ready,
	input wire m_last,
	output logic m_abort,
	// Pointer flags
	input wire full,
	input wire empty,
	input wire eop_at_head,
	// Pointer and memory control
	output fifo_ctrl_pkg::wr_op_t wr_op,
	output logic rd_adv,
	output logic mem_wr
);

	fifo_ctrl_pkg::pkt_state_t pkt_state;
	logic w_wr;
	logic abort_hon;
	logic lastv;
	logic r_midpacket;

	//////////////////////////////
	// Handshakes
	//////////////////////////////

	// Abort always takes the beat, so the source can drop it
	assign s_ready = !full || s_abort;
	assign m_valid = !empty;

	// Accepted beat, never one flagged as abort
	assign w_wr = s_valid && s_ready && !s_abort;
	assign rd_adv = m_valid && m_ready;

	// Abort counts only between first and last beat
	assign abort_hon = s_abort && (pkt_state == fifo_ctrl_pkg::pkt_body);

	// Opcode decode, abort wins over a push
	always_comb
	begin
		if (abort_hon)
			wr_op = lastv ? fifo_ctrl_pkg::wr_rewind_eop : fifo_ctrl_pkg::wr_rewind_read;
		else if (w_wr)
			wr_op = s_last ? fifo_ctrl_pkg::wr_push_eop : fifo_ctrl_pkg::wr_push;
		else
			wr_op = fifo_ctrl_pkg::wr_hold;
	end

	// Memory write on either push flavour
	assign mem_wr = (wr_op == fifo_ctrl_pkg::wr_push) || (wr_op == fifo_ctrl_pkg::wr_push_eop);

	//////////////////////////////
	// Packet tracking
	//////////////////////////////

	// Write side state
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			pkt_state <= fifo_ctrl_pkg::pkt_idle;
		else if (s_abort)
			pkt_state <= fifo_ctrl_pkg::pkt_idle;
		else if (w_wr)
			pkt_state <= s_last ? fifo_ctrl_pkg::pkt_idle : fifo_ctrl_pkg::pkt_body;
	end

	// Complete packet stored behind the head
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			lastv <= 1'b0;
		else if (w_wr && s_last && !empty)
			lastv <= 1'b1;
		else if (rd_adv && eop_at_head)
			lastv <= 1'b0;
	end

	// Read side is partway through a packet
	// Last consumed beat was not an end of packet
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_midpacket <= 1'b0;
		else if (rd_adv)
			r_midpacket <= !m_last;
	end

	//////////////////////////////
	// Downstream abort
	//////////////////////////////

	// Raised when part of a dropped packet already went out
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			m_abort <= 1'b0;
		else if (!m_abort)
			m_abort <= !lastv && abort_hon && (m_valid || r_midpacket);
		else if (!m_valid || m_ready)
			m_abort <= 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/fifo_pointers.sv */
// Packet FIFO pointer unit
// Write, read and end-of-packet pointers with rewind support
// Full, empty and EOP-at-head flags come straight from the pointers

`timescale 1ns/100ps
`default_nettype none

`include "netfifo_config.svh"

module fifo_pointers (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	input wire fifo_ctrl_pkg::wr_op_t wr_op,
	input wire rd_adv,
	output stream_pkg::index_t wr_index,
	output stream_pkg::index_t rd_index,
	output logic full,
	output logic empty,
	output logic eop_at_head
);

	stream_pkg::ptr_t wr_ptr;
	stream_pkg::ptr_t rd_ptr;
	stream_pkg::ptr_t eop_ptr;
	stream_pkg::ptr_t fill;

	//////////////////////////////
	// Write and EOP pointers
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			eop_ptr <= '0;
		end
		else
		begin
			case (wr_op)
			fifo_ctrl_pkg::wr_push:
				wr_ptr <= wr_ptr + 1'b1;
			fifo_ctrl_pkg::wr_push_eop:
			begin
				// Remember where this packet ends
				eop_ptr <= wr_ptr;
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Back up to just past the last whole packet
			fifo_ctrl_pkg::wr_rewind_eop:
				wr_ptr <= eop_ptr + 1'b1;
			fifo_ctrl_pkg::wr_rewind_read:
			begin
				// Keep the head beat if it is already on the output
				if (empty)
					wr_ptr <= rd_ptr;
				else
					wr_ptr <= rd_ptr + 1'b1;
			end
			default:
				wr_ptr <= wr_ptr;
			endcase
		end
	end

	// Read pointer, one step per consumed beat
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_ptr <= '0;
		else if (rd_adv)
			rd_ptr <= rd_ptr + 1'b1;
	end

	//////////////////////////////
	// Flags
	//////////////////////////////

	// Fill level, top bit set only at depth
	assign fill = wr_ptr - rd_ptr;
	assign full = fill[`NETFIFO_LG_DEPTH];
	assign empty = (wr_ptr == rd_ptr);
	assign eop_at_head = (eop_ptr == rd_ptr);

	// Wrap bit dropped for memory addressing
	assign wr_index = wr_ptr[`NETFIFO_LG_DEPTH-1:0];
	assign rd_index = rd_ptr[`NETFIFO_LG_DEPTH-1:0];

endmodule

`default_nettype wire

/* verilog/packet_mem.sv */
// Packet FIFO storage
// Circular array of data words with their last flags, asynchronous head read

`timescale 1ns/100ps
`default_nettype none

`include "netfifo_config.svh"

module packet_mem (
	input wire S_AXI_ACLK,
	input wire wr_en,
	input wire stream_pkg::index_t wr_index,
	input wire stream_pkg::data_t wr_data,
	input wire wr_last,
	input wire stream_pkg::index_t rd_index,
	output stream_pkg::data_t rd_data,
	output logic rd_last
);

	localparam int DEPTH = 1 << `NETFIFO_LG_DEPTH;

	// Payload and end-of-packet flag, side by side
	stream_pkg::data_t mem_data [DEPTH];
	logic mem_last [DEPTH];

	// Write lands at the clock edge
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_en)
		begin
			mem_data[wr_index] <= wr_data;
			mem_last[wr_index] <= wr_last;
		end
	end

	// Head read, same cycle as the pointer
	assign rd_data = mem_data[rd_index];
	assign rd_last = mem_last[rd_index];

endmodule

`default_nettype wire

/* verilog/abortable_packet_fifo.sv */
// Abortable packet FIFO, top level
// Byte stream in with last and abort, same stream out
// A partial packet is dropped on abort, downstream told if already seen

`timescale 1ns/100ps
`default_nettype none

module abortable_packet_fifo (
	input wire S_AXI_ACLK,
	input wire S_AXI_ARESETN,
	// Source side
	input wire s_valid,
	output logic s_ready,
	input wire stream_pkg::data_t s_data,
	input wire s_last,
	input wire s_abort,
	// Sink side
	output logic m_valid,
	input wire m_ready,
	output stream_pkg::data_t m_data,
	output logic m_last,
	output logic m_abort
);

	// Control to pointers and memory
	fifo_ctrl_pkg::wr_op_t wr_op;
	logic rd_adv;
	logic mem_wr;

	// Pointer flags back to control
	logic full;
	logic empty;
	logic eop_at_head;

	// Memory addresses
	stream_pkg::index_t wr_index;
	stream_pkg::index_t rd_index;

	//////////////////////////////
	// Control
	//////////////////////////////

	packet_fifo_ctrl packet_fifo_ctrl_inst (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.s_valid(s_valid),
		.s_last(s_last),
		.s_abort(s_abort),
		.s_ready(s_ready),
		.m_valid(m_valid),
		.m_ready(m_ready),
		// Head last flag straight from memory
		.m_last(m_last),
		.m_abort(m_abort),
		.full(full),
		.empty(empty),
		.eop_at_head(eop_at_head),
		.wr_op(wr_op),
		.rd_adv(rd_adv),
		.mem_wr(mem_wr)
	);

	//////////////////////////////
	// Datapath
	//////////////////////////////

	fifo_pointers fifo_pointers_inst (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_op(wr_op),
		.rd_adv(rd_adv),
		.wr_index(wr_index),
		.rd_index(rd_index),
		.full(full),
		.empty(empty),
		.eop_at_head(eop_at_head)
	);

	// Stream payload written directly from the source
	packet_mem packet_mem_inst (
		.S_AXI_ACLK(S_AXI_ACLK),
		.wr_en(mem_wr),
		.wr_index(wr_index),
		.wr_data(s_data),
		.wr_last(s_last),
		.rd_index(rd_index),
		.rd_data(m_data),
		.rd_last(m_last)
	);

endmodule

`default_nettype wire

/* tests/tb_abortable_packet_fifo.sv */
// Testbench for the abortable packet FIFO
// Replays a per-cycle trace of stimulus and expected outputs

`timescale 1ns/100ps
`default_nettype none

module tb_abortable_packet_fifo;

	// Ten hex fields per trace row
	localparam int TRACE_ROWS = 49;
	localparam int ROW_FIELDS = 10;
	localparam int RESET_CYCLES = 16;
	// Rows plus reset plus margin, in 40 ns cycles
	localparam int WATCHDOG_NS = (TRACE_ROWS + RESET_CYCLES + 20) * 40;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic s_valid;
	logic s_ready;
	stream_pkg::data_t s_data;
	logic s_last;
	logic s_abort;
	logic m_valid;
	logic m_ready;
	stream_pkg::data_t m_data;
	logic m_last;
	logic m_abort;

	logic [7:0] trace [TRACE_ROWS*ROW_FIELDS];
	int errors;
	int checks;

	abortable_packet_fifo abortable_packet_fifo_inst (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.s_data(s_data),
		.s_last(s_last),
		.s_abort(s_abort),
		.m_valid(m_valid),
		.m_ready(m_ready),
		.m_data(m_data),
		.m_last(m_last),
		.m_abort(m_abort)
	);

	// 40 ns clock
	initial S_AXI_ACLK = 1'b0;
	always #20 S_AXI_ACLK = ~S_AXI_ACLK;

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_bit(input string name, input int row, input logic expected,
		input logic actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error row %0d: %s expected 0x%h, got 0x%h", row, name, expected, actual);
		end
	endtask

	task automatic check_data(input string name, input int row,
		input stream_pkg::data_t expected, input stream_pkg::data_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("** Error row %0d: %s expected 0x%h, got 0x%h", row, name, expected, actual);
		end
	endtask

	//////////////////////////////
	// Trace rows
	//////////////////////////////

	// Source and sink inputs, fields 0 to 4
	task automatic apply_row(input int row);
		int base;
		base = row * ROW_FIELDS;
		s_valid = trace[base][0];
		s_data = stream_pkg::data_t'(trace[base+1]);
		s_last = trace[base+2][0];
		s_abort = trace[base+3][0];
		m_ready = trace[base+4][0];
	endtask

	// Expected outputs, fields 5 to 9
	task automatic compare_row(input int row);
		int base;
		base = row * ROW_FIELDS;
		check_bit("s_ready", row, trace[base+5][0], s_ready);
		check_bit("m_valid", row, trace[base+6][0], m_valid);
		check_bit("m_abort", row, trace[base+9][0], m_abort);
		// Head payload only defined while a beat is offered
		if (trace[base+6][0])
		begin
			check_data("m_data", row, stream_pkg::data_t'(trace[base+7]), m_data);
			check_bit("m_last", row, trace[base+8][0], m_last);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		errors = 0;
		checks = 0;
		S_AXI_ARESETN = 1'b0;
		s_valid = 1'b0;
		s_data = '0;
		s_last = 1'b0;
		s_abort = 1'b0;
		m_ready = 1'b0;
		// Marker left in any slot the trace file does not reach
		foreach (trace[i])
			trace[i] = 8'hff;
		$readmemh("tests/packet_trace.txt", trace);
		// Last field is a flag, so a marker there means a short file
		if (trace[TRACE_ROWS*ROW_FIELDS-1] > 8'h01)
		begin
			errors++;
			$display("Trace file is missing or shorter than expected");
		end
		// Reset low for 16 rising edges
		repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
		#2;
		S_AXI_ARESETN = 1'b1;
		// Drive 2 ns after the edge, sample 2 ns before the next
		for (int row = 0; row < TRACE_ROWS; row++)
		begin
			@(posedge S_AXI_ACLK);
			#2;
			apply_row(row);
			#36;
			compare_row(row);
		end
		$display("Trace rows %0d, checks %0d, errors %0d", TRACE_ROWS, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout, the trace did not finish within %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/packet_trace.txt */
// s_valid s_data s_last s_abort m_ready | s_ready m_valid m_data m_last m_abort (expected)
// m_data and m_last are checked only on rows where m_valid is expected high
0 00 0 1 0  1 0 00 0 0
1 11 0 0 0  1 0 00 0 0
1 12 0 0 0  1 1 11 0 0
1 13 1 0 0  1 1 11 0 0
0 00 0 0 1  1 1 11 0 0
0 00 0 0 1  1 1 12 0 0
0 00 0 0 1  1 1 13 1 0
0 00 0 0 0  1 0 00 0 0
1 20 0 0 0  1 0 00 0 0
1 21 0 0 0  1 1 20 0 0
1 22 0 0 0  1 1 20 0 0
1 23 0 0 0  1 1 20 0 0
1 24 0 0 0  1 1 20 0 0
1 25 0 0 0  1 1 20 0 0
1 26 0 0 0  1 1 20 0 0
1 27 0 0 0  1 1 20 0 0
1 28 0 0 0  1 1 20 0 0
1 29 0 0 0  1 1 20 0 0
1 2a 0 0 0  1 1 20 0 0
1 2b 0 0 0  1 1 20 0 0
1 2c 0 0 0  1 1 20 0 0
1 2d 0 0 0  1 1 20 0 0
1 2e 0 0 0  1 1 20 0 0
1 2f 1 0 0  1 1 20 0 0
1 30 0 0 0  0 1 20 0 0
1 30 0 0 1  0 1 20 0 0
1 30 0 0 0  1 1 21 0 0
0 00 0 1 1  1 1 21 0 0
0 00 0 0 1  1 1 22 0 0
0 00 0 0 1  1 1 23 0 0
0 00 0 0 1  1 1 24 0 0
0 00 0 0 1  1 1 25 0 0
0 00 0 0 1  1 1 26 0 0
0 00 0 0 1  1 1 27 0 0
0 00 0 0 1  1 1 28 0 0
0 00 0 0 1  1 1 29 0 0
0 00 0 0 1  1 1 2a 0 0
0 00 0 0 1  1 1 2b 0 0
0 00 0 0 1  1 1 2c 0 0
0 00 0 0 1  1 1 2d 0 0
0 00 0 0 1  1 1 2e 0 0
0 00 0 0 1  1 1 2f 1 0
0 00 0 0 0  1 0 00 0 0
1 40 0 0 0  1 0 00 0 0
1 41 0 0 0  1 1 40 0 0
0 00 0 1 0  1 1 40 0 0
0 00 0 0 0  1 1 40 0 1
0 00 0 0 1  1 1 40 0 1
0 00 0 0 0  1 0 00 0 0

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the abortable packet FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f files.f \
	--top-module tb_abortable_packet_fifo -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* files.f */
+incdir+include
verilog/stream_pkg.sv
verilog/fifo_ctrl_pkg.sv
verilog/packet_fifo_ctrl.sv
verilog/fifo_pointers.sv
verilog/packet_mem.sv
verilog/abortable_packet_fifo.sv
tests/tb_abortable_packet_fifo.sv
